// File: rv_settings.svh
// RV32 only: the immediate and ALU code assumes RV_XLEN is 32 and the bus uses word addresses
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width
`define RV_XLEN 32

// Unified memory depth in words
`define RV_MEM_WORDS 1024

// Word address width, which also sets the host address range
`define RV_ADDR_W $clog2(`RV_MEM_WORDS)

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
// Control and bus types for the multi-cycle core; field widths are fixed for RV32I
`default_nettype none

package rv_pkg;

    typedef enum logic [1:0] {
        resAlu = 2'b00,
        resMem = 2'b01,
        resPc4 = 2'b10
    } resultSrcT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01,
        aluFunct  = 2'b10,
        aluPass   = 2'b11
    } aluOpT;

    typedef struct packed {
        logic      branch;
        logic      jump;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      aluSrcA;   // 1 selects PC
        logic      aluSrcB;   // 1 selects immediate
        immSrcT    immSrc;
        logic      regWrite;
        aluOpT     aluOp;
        logic      ldSrc;     // Unsigned load
        logic      stSrc;     // Word access
    } ctrlT;

    typedef enum logic [1:0] {
        reqHost  = 2'd0,
        reqLsu   = 2'd1,
        reqFetch = 2'd2
    } requesterT;

endpackage

`default_nettype wire

// File: mem_bus_if.sv
// One requester to memory link; req and fields must hold until gnt, rvalid comes one cycle later
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

interface mem_bus_if;

    logic                    req;
    logic                    we;
    logic [`RV_ADDR_W-1:0]   addr;     // Word address
    logic [`RV_XLEN-1:0]     wdata;
    logic [`RV_XLEN/8-1:0]   strb;
    logic [`RV_XLEN-1:0]     rdata;
    logic                    gnt;
    logic                    rvalid;

    modport requester (
        output req, we, addr, wdata, strb,
        input  rdata, gnt, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata, strb,
        output rdata, gnt, rvalid
    );

endinterface

`default_nettype wire

// File: main_decode.sv
// Combinational RV32I-subset decoder; unknown opcodes decode to a no-write, no-branch default
`timescale 1ns/1ps
`default_nettype none

module main_decode (
    input  logic [6:0]   opcode,
    input  logic [2:0]   func3,
    output rv_pkg::ctrlT ctrl
);

    always_comb begin
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.resultSrc = rv_pkg::resAlu;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrcA   = 1'b0;
        ctrl.aluSrcB   = 1'b0;
        ctrl.immSrc    = rv_pkg::immI;
        ctrl.regWrite  = 1'b0;
        ctrl.aluOp     = rv_pkg::aluAdd;
        ctrl.ldSrc     = 1'b0;
        ctrl.stSrc     = 1'b0;

        case (opcode)
            7'b0110011: begin // R-type
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rv_pkg::aluFunct;
            end
            7'b0010011: begin // I-type ALU
                ctrl.aluSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rv_pkg::aluFunct;
            end
            7'b0000011: begin // Loads
                ctrl.resultSrc = rv_pkg::resMem;
                ctrl.aluSrcB   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.ldSrc     = func3[2];
                ctrl.stSrc     = func3[1]; // LW uses the word path too
            end
            7'b1100111: begin // JALR
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = rv_pkg::resPc4;
                ctrl.aluSrcB   = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            7'b0100011: begin // Stores
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = rv_pkg::immS;
                ctrl.stSrc    = func3[1];
            end
            7'b1100011: begin // BEQ, BNE
                ctrl.branch = 1'b1;
                ctrl.immSrc = rv_pkg::immB;
                ctrl.aluOp  = rv_pkg::aluBranch;
            end
            7'b0110111: begin // LUI
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = rv_pkg::immU;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rv_pkg::aluPass;
            end
            7'b0010111: begin // AUIPC
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = rv_pkg::immU;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rv_pkg::aluPass;
            end
            7'b1101111: begin // JAL, target from PC + imm
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = rv_pkg::resPc4;
                ctrl.aluSrcA   = 1'b1;
                ctrl.aluSrcB   = 1'b1;
                ctrl.immSrc    = rv_pkg::immJ;
                ctrl.regWrite  = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rv_core.sv
// Multi-cycle RV32I-subset core; one instruction in flight, stops for good on the word JAL x0, 0
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_core (
    input  logic                clk,
    input  logic                rstN,
    input  logic                run,
    output logic                halted,
    mem_bus_if.requester        fetchBus,
    output logic [6:0]          opcode,
    output logic [2:0]          func3,
    input  rv_pkg::ctrlT        ctrl,
    output logic                lsuStart,
    output logic [`RV_XLEN-1:0] lsuAddr,
    output logic [`RV_XLEN-1:0] lsuWdata,
    input  logic                lsuDone,
    input  logic [`RV_XLEN-1:0] lsuRdata
);

    localparam logic [`RV_XLEN-1:0] haltWord = 32'h0000_006f;

    typedef enum logic [2:0] {sIdle, sFetch, sExecute, sMemory, sWriteback, sHalt} stateT;

    stateT               state;
    logic                fetchPending;
    logic [`RV_XLEN-1:0] pc, instr, loadQ, imm, srcA, srcB, aluResult, result, nextPc;
    logic [`RV_XLEN-1:0] rs1Val, rs2Val;
    logic [`RV_XLEN-1:0] rf [32];
    logic                memAccess, taken;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign halted = (state == sHalt);

    assign fetchBus.req   = ((state == sIdle && run) || state == sFetch) && !fetchPending;
    assign fetchBus.we    = 1'b0;
    assign fetchBus.addr  = pc[`RV_ADDR_W+1:2];
    assign fetchBus.wdata = '0;
    assign fetchBus.strb  = '0;

    assign rs1Val = (instr[19:15] == 5'd0) ? '0 : rf[instr[19:15]];
    assign rs2Val = (instr[24:20] == 5'd0) ? '0 : rf[instr[24:20]];

    always_comb begin
        case (ctrl.immSrc)
            rv_pkg::immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            rv_pkg::immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
            rv_pkg::immU: imm = {instr[31:12], 12'b0};
            default:      imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    assign srcA = ctrl.aluSrcA ? pc : rs1Val;
    assign srcB = ctrl.aluSrcB ? imm : rs2Val;

    always_comb begin
        aluResult = srcA + srcB;
        case (ctrl.aluOp)
            rv_pkg::aluBranch: aluResult = srcA - srcB;
            rv_pkg::aluPass:   aluResult = ctrl.aluSrcA ? srcA + srcB : srcB; // AUIPC or LUI
            rv_pkg::aluFunct: begin
                case (func3)
                    3'd0: aluResult = (opcode[5] && instr[30]) ? srcA - srcB : srcA + srcB;
                    3'd1: aluResult = srcA << srcB[4:0];
                    3'd2: aluResult = {{(`RV_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
                    3'd3: aluResult = {{(`RV_XLEN-1){1'b0}}, srcA < srcB};
                    3'd4: aluResult = srcA ^ srcB;
                    3'd5: aluResult = instr[30] ? $unsigned($signed(srcA) >>> srcB[4:0])
                                                : srcA >> srcB[4:0];
                    3'd6: aluResult = srcA | srcB;
                    default: aluResult = srcA & srcB;
                endcase
            end
            default: ;
        endcase
    end

    assign taken     = ctrl.branch && (func3[0] ? (aluResult != '0) : (aluResult == '0));
    assign memAccess = ctrl.memWrite || (ctrl.resultSrc == rv_pkg::resMem);
    assign nextPc    = ctrl.jump ? {aluResult[`RV_XLEN-1:1], 1'b0} :
                       taken     ? pc + imm : pc + 4;

    always_comb begin
        case (ctrl.resultSrc)
            rv_pkg::resMem: result = loadQ;
            rv_pkg::resPc4: result = pc + 4;
            default:        result = aluResult;
        endcase
    end

    assign lsuStart = (state == sExecute) && memAccess;
    assign lsuAddr  = aluResult;
    assign lsuWdata = rs2Val;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= sIdle;
            pc           <= `RV_RESET_PC;
            fetchPending <= 1'b0;
        end else begin
            if (fetchBus.gnt)
                fetchPending <= 1'b1;
            else if (fetchBus.rvalid)
                fetchPending <= 1'b0;
            case (state)
                sIdle:      if (run) state <= sFetch;
                sFetch:     if (fetchBus.rvalid)
                                state <= (fetchBus.rdata == haltWord) ? sHalt : sExecute;
                sExecute:   state <= memAccess ? sMemory : sWriteback;
                sMemory:    if (lsuDone) state <= sWriteback;
                sWriteback: begin
                    pc    <= nextPc;
                    state <= sFetch;
                end
                default:    state <= sHalt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sFetch && fetchBus.rvalid)
            instr <= fetchBus.rdata;
        if (lsuDone)
            loadQ <= lsuRdata;
        if (state == sWriteback && ctrl.regWrite && instr[11:7] != 5'd0)
            rf[instr[11:7]] <= result;
    end

endmodule

`default_nettype wire

// File: load_store_unit.sv
// Byte and word loads and stores only; addresses are assumed aligned, halfwords are not handled
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module load_store_unit (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] wdata,
    input  rv_pkg::ctrlT        ctrl,
    output logic                done,
    output logic [`RV_XLEN-1:0] rdata,
    mem_bus_if.requester        dataBus
);

    logic                reqQ;
    logic                weQ, unsignedQ, wordQ;
    logic [`RV_XLEN-1:0] addrQ, wdataQ;
    logic [7:0]          loadByte;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            reqQ <= 1'b0;
        else if (start)
            reqQ <= 1'b1;
        else if (dataBus.gnt)
            reqQ <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addrQ     <= addr;
            wdataQ    <= wdata;
            weQ       <= ctrl.memWrite;
            unsignedQ <= ctrl.ldSrc;
            wordQ     <= ctrl.stSrc;
        end
    end

    assign dataBus.req   = reqQ;
    assign dataBus.we    = weQ;
    assign dataBus.addr  = addrQ[`RV_ADDR_W+1:2];
    assign dataBus.wdata = wordQ ? wdataQ : {(`RV_XLEN/8){wdataQ[7:0]}}; // Byte in every lane
    assign dataBus.strb  = wordQ ? '1 : (`RV_XLEN/8)'(1) << addrQ[1:0];

    assign loadByte = dataBus.rdata[addrQ[1:0]*8 +: 8];
    assign rdata    = wordQ     ? dataBus.rdata :
                      unsignedQ ? {{(`RV_XLEN-8){1'b0}}, loadByte} :
                                  {{(`RV_XLEN-8){loadByte[7]}}, loadByte};
    assign done     = dataBus.rvalid;

endmodule

`default_nettype wire

// File: bus_arbiter.sv
// Fixed priority host, lsu, fetch; the memory must grant in the same cycle it sees req
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic         clk,
    input  logic         rstN,
    mem_bus_if.arbiter   host,
    mem_bus_if.arbiter   lsu,
    mem_bus_if.arbiter   fetch,
    mem_bus_if.requester mem
);

    rv_pkg::requesterT sel, ownerQ;
    logic              ownerValidQ;

    always_comb begin
        sel = rv_pkg::reqFetch;
        if (host.req)
            sel = rv_pkg::reqHost;
        else if (lsu.req)
            sel = rv_pkg::reqLsu;

        mem.req = host.req || lsu.req || fetch.req;
        case (sel)
            rv_pkg::reqHost: begin
                mem.we = host.we;
                mem.addr = host.addr;
                mem.wdata = host.wdata;
                mem.strb = host.strb;
            end
            rv_pkg::reqLsu: begin
                mem.we = lsu.we;
                mem.addr = lsu.addr;
                mem.wdata = lsu.wdata;
                mem.strb = lsu.strb;
            end
            default: begin
                mem.we = fetch.we;
                mem.addr = fetch.addr;
                mem.wdata = fetch.wdata;
                mem.strb = fetch.strb;
            end
        endcase
    end

    assign host.gnt  = mem.gnt && (sel == rv_pkg::reqHost);
    assign lsu.gnt   = mem.gnt && (sel == rv_pkg::reqLsu);
    assign fetch.gnt = mem.gnt && (sel == rv_pkg::reqFetch);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ownerQ      <= rv_pkg::reqHost;
            ownerValidQ <= 1'b0;
        end else begin
            ownerValidQ <= mem.gnt;
            if (mem.gnt)
                ownerQ <= sel; // Routes next cycle's rvalid
        end
    end

    assign host.rvalid  = mem.rvalid && ownerValidQ && (ownerQ == rv_pkg::reqHost);
    assign lsu.rvalid   = mem.rvalid && ownerValidQ && (ownerQ == rv_pkg::reqLsu);
    assign fetch.rvalid = mem.rvalid && ownerValidQ && (ownerQ == rv_pkg::reqFetch);
    assign host.rdata   = mem.rdata;
    assign lsu.rdata    = mem.rdata;
    assign fetch.rdata  = mem.rdata;

endmodule

`default_nettype wire

// File: unified_mem.sv
// Single-port word memory, no reset and no init; rvalid follows every grant, writes included
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module unified_mem (
    input logic        clk,
    mem_bus_if.arbiter port
);

    logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];

    assign port.gnt = port.req; // Never busy

    always_ff @(posedge clk) begin
        port.rvalid <= port.req;
        if (port.req) begin
            port.rdata <= mem[port.addr]; // Old contents on a write
        end
    end

    always_ff @(posedge clk) begin
        if (port.req && port.we) begin
            for (int b = 0; b < `RV_XLEN/8; b++) begin
                if (port.strb[b])
                    mem[port.addr][b*8 +: 8] <= port.wdata[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: rv_top.sv
// Core, LSU, arbiter and memory; host writes are always full words, host addresses are word indexes
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_top (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   run,
    output logic                   halted,
    input  logic                   hostReq,
    input  logic                   hostWe,
    input  logic [`RV_ADDR_W-1:0]  hostAddr,
    input  logic [`RV_XLEN-1:0]    hostWdata,
    output logic                   hostGnt,
    output logic                   hostRvalid,
    output logic [`RV_XLEN-1:0]    hostRdata
);

    mem_bus_if hostBus ();
    mem_bus_if lsuBus ();
    mem_bus_if fetchBus ();
    mem_bus_if memBus ();

    rv_pkg::ctrlT        ctrl;
    logic [6:0]          opcode;
    logic [2:0]          func3;
    logic                lsuStart, lsuDone;
    logic [`RV_XLEN-1:0] lsuAddr, lsuWdata, lsuRdata;

    assign hostBus.req   = hostReq;
    assign hostBus.we    = hostWe;
    assign hostBus.addr  = hostAddr;
    assign hostBus.wdata = hostWdata;
    assign hostBus.strb  = '1;
    assign hostGnt       = hostBus.gnt;
    assign hostRvalid    = hostBus.rvalid;
    assign hostRdata     = hostBus.rdata;

    rv_core core (
        .clk, .rstN, .run, .halted,
        .fetchBus (fetchBus.requester),
        .opcode, .func3, .ctrl,
        .lsuStart, .lsuAddr, .lsuWdata, .lsuDone, .lsuRdata
    );

    main_decode decoder (.opcode, .func3, .ctrl);

    load_store_unit lsu (
        .clk, .rstN,
        .start (lsuStart), .addr (lsuAddr), .wdata (lsuWdata), .ctrl,
        .done (lsuDone), .rdata (lsuRdata),
        .dataBus (lsuBus.requester)
    );

    bus_arbiter arbiter (
        .clk, .rstN,
        .host (hostBus.arbiter), .lsu (lsuBus.arbiter), .fetch (fetchBus.arbiter),
        .mem (memBus.requester)
    );

    unified_mem memory (.clk, .port (memBus.arbiter));

endmodule

`default_nettype wire

// File: rv_props.sv
// Bus and halt properties bound into rv_top; they assume memory grants in the cycle of a request
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_props (
    input logic clk,
    input logic rstN,
    input logic halted,
    input logic hostReq, lsuReq, fetchReq,
    input logic hostGnt, lsuGnt, fetchGnt,
    input logic hostRvalid, lsuRvalid, fetchRvalid,
    input logic [`RV_ADDR_W+`RV_XLEN+`RV_XLEN/8:0] hostFields, lsuFields, fetchFields
);

    localparam int fieldW = `RV_ADDR_W + `RV_XLEN + `RV_XLEN/8 + 1;

    int                     propFails = 0;  // Read by the testbench at the end
    logic [2:0]             req, gnt, rvalid;
    logic [2:0][fieldW-1:0] fields;

    assign req[rv_pkg::reqHost]     = hostReq;
    assign req[rv_pkg::reqLsu]      = lsuReq;
    assign req[rv_pkg::reqFetch]    = fetchReq;
    assign gnt[rv_pkg::reqHost]     = hostGnt;
    assign gnt[rv_pkg::reqLsu]      = lsuGnt;
    assign gnt[rv_pkg::reqFetch]    = fetchGnt;
    assign rvalid[rv_pkg::reqHost]  = hostRvalid;
    assign rvalid[rv_pkg::reqLsu]   = lsuRvalid;
    assign rvalid[rv_pkg::reqFetch] = fetchRvalid;
    assign fields[rv_pkg::reqHost]  = hostFields;
    assign fields[rv_pkg::reqLsu]   = lsuFields;
    assign fields[rv_pkg::reqFetch] = fetchFields;

    grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(gnt))
    else begin
        propFails++;
        $error("More than one requester granted in one cycle");
    end

    haltSticky: assert property (@(posedge clk) disable iff (!rstN) !$fell(halted))
    else begin
        propFails++;
        $error("halted fell while out of reset");
    end

    for (genvar i = 0; i < 3; i++) begin : perPeer
        rvalidAfterGnt: assert property (@(posedge clk) disable iff (!rstN)
                                         gnt[i] |=> rvalid[i])
        else begin
            propFails++;
            $error("Requester %0d got no rvalid one cycle after gnt", i);
        end

        rvalidNeedsGnt: assert property (@(posedge clk) disable iff (!rstN)
                                         rvalid[i] |-> $past(gnt[i]))
        else begin
            propFails++;
            $error("Requester %0d got rvalid without a gnt one cycle before", i);
        end

        reqHeld: assert property (@(posedge clk) disable iff (!rstN)
                                  req[i] && !gnt[i] |=> req[i] && $stable(fields[i]))
        else begin
            propFails++;
            $error("Requester %0d dropped or changed its request before gnt", i);
        end
    end

endmodule

bind rv_top rv_props props (
    .clk, .rstN, .halted,
    .hostReq     (hostBus.req),
    .lsuReq      (lsuBus.req),
    .fetchReq    (fetchBus.req),
    .hostGnt     (hostBus.gnt),
    .lsuGnt      (lsuBus.gnt),
    .fetchGnt    (fetchBus.gnt),
    .hostRvalid  (hostBus.rvalid),
    .lsuRvalid   (lsuBus.rvalid),
    .fetchRvalid (fetchBus.rvalid),
    .hostFields  ({hostBus.we, hostBus.addr, hostBus.wdata, hostBus.strb}),
    .lsuFields   ({lsuBus.we, lsuBus.addr, lsuBus.wdata, lsuBus.strb}),
    .fetchFields ({fetchBus.we, fetchBus.addr, fetchBus.wdata, fetchBus.strb})
);

`default_nettype wire

// File: rv_tb.sv
// Loads a program over the host port and runs it to the halt word; host addresses are word indexes
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_tb;

    localparam int gntLimit   = 50;
    localparam int haltLimit  = 5000;
    localparam int opImm      = 'h13;
    localparam int opLoad     = 'h03;
    localparam int opJalr     = 'h67;
    localparam int opLui      = 'h37;
    localparam int opAuipc    = 'h17;
    localparam int dataBase   = 384;     // Byte 0x600
    localparam int resultBase = 448;     // Byte 0x700
    localparam logic [31:0] dataWord = 32'h1a8c_e37f;

    logic                  clk, rstN, run, halted;
    logic                  hostReq, hostWe, hostGnt, hostRvalid;
    logic [`RV_ADDR_W-1:0] hostAddr;
    logic [`RV_XLEN-1:0]   hostWdata, hostRdata;

    logic [31:0] prog [$];
    string       expName [$];
    int          expAddr [$];
    logic [31:0] expVal [$];
    int          resultSlots, checks, errors, timeouts;
    integer      seed;

    rv_top uut (
        .clk, .rstN, .run, .halted,
        .hostReq, .hostWe, .hostAddr, .hostWdata,
        .hostGnt, .hostRvalid, .hostRdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rType(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] sType(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input logic [31:0] imm, rd, op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] fillWord(input int a);
        return (a * 32'h0103_0507) ^ 32'ha5c3_e1f0;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic addExpected(input string name, input int a, input logic [31:0] v);
        expName.push_back(name);
        expAddr.push_back(a);
        expVal.push_back(v);
    endtask

    // SW of a register into the next result slot
    task automatic storeResult(input int rs, input string name, input logic [31:0] v);
        emit(sType(4 * resultSlots, rs, 10, 2));
        addExpected(name, resultBase + resultSlots, v);
        resultSlots++;
    endtask

    task automatic buildProgram();
        int          a, b, k, pcMark;
        logic [31:0] w;
        a = 100;
        b = -7;
        emit(iType(a, 0, 0, 1, opImm));
        emit(iType(b, 0, 0, 2, opImm));
        emit(iType('h700, 0, 0, 10, opImm));
        emit(iType('h600, 0, 0, 11, opImm));
        emit(rType('h00, 2, 1, 0, 3));
        storeResult(3, "add", a + b);
        emit(rType('h20, 2, 1, 0, 4));
        storeResult(4, "sub", a - b);
        emit(rType('h00, 2, 1, 4, 5));
        storeResult(5, "xor", a ^ b);
        emit(rType('h00, 1, 2, 2, 6));          // x2 < x1, signed
        storeResult(6, "slt", (b < a) ? 1 : 0);
        emit(iType(-150, 1, 0, 7, opImm));
        storeResult(7, "addi", a - 150);
        emit(iType('hf0, 2, 7, 8, opImm));
        storeResult(8, "andi", b & 'hf0);
        emit(iType(1, 11, 0, 12, opLoad));
        storeResult(12, "lb", {{24{dataWord[15]}}, dataWord[15:8]});
        emit(iType(1, 11, 4, 13, opLoad));
        storeResult(13, "lbu", {24'h0, dataWord[15:8]});
        emit(iType(0, 11, 2, 14, opLoad));
        storeResult(14, "lw", dataWord);
        for (k = 0; k < 4; k++) begin
            emit(sType(4 * k + 4 + k, 2, 11, 0));  // Word dataBase+1+k, lane k
            w = fillWord(dataBase + 1 + k);
            w[8*k +: 8] = 8'hf9;
            addExpected($sformatf("sb lane %0d", k), dataBase + 1 + k, w);
        end
        emit(iType(55, 0, 0, 20, opImm));
        emit(iType(66, 0, 0, 22, opImm));
        emit(bType(8, 1, 1, 0));                 // BEQ taken
        emit(iType(1, 0, 0, 20, opImm));
        emit(bType(8, 1, 1, 1));                 // BNE not taken
        emit(iType(2, 0, 0, 21, opImm));
        emit(bType(8, 2, 1, 1));                 // BNE taken
        emit(iType(3, 0, 0, 22, opImm));
        emit(bType(8, 2, 1, 0));                 // BEQ not taken
        emit(iType(4, 0, 0, 23, opImm));
        storeResult(20, "beq taken", 55);
        storeResult(21, "bne not taken", 2);
        storeResult(22, "bne taken", 66);
        storeResult(23, "beq not taken", 4);
        emit(iType(77, 0, 0, 25, opImm));
        pcMark = 4 * prog.size();
        emit(jType(8, 24));
        emit(iType(9, 0, 0, 25, opImm));
        storeResult(24, "jal link", pcMark + 4);
        storeResult(25, "jal skip", 77);
        pcMark = 4 * prog.size();
        emit(uType(0, 26, opAuipc));
        emit(iType(13, 26, 0, 27, opJalr));     // Odd target, bit 0 dropped
        emit(iType(5, 0, 0, 25, opImm));
        storeResult(27, "jalr link", pcMark + 8);
        storeResult(25, "jalr skip", 77);
        storeResult(26, "auipc zero", pcMark);
        emit(uType('habcde, 29, opLui));
        storeResult(29, "lui", 32'habcd_e000);
        pcMark = 4 * prog.size();
        emit(uType('h12345, 30, opAuipc));
        storeResult(30, "auipc", pcMark + 32'h1234_5000);
        emit(jType(0, 0));                       // Halt word
    endtask

    task automatic waitGrant(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < gntLimit && !ok; n++) begin
            @(posedge clk);
            ok = hostGnt;
        end
    endtask

    task automatic hostWrite(input int a, input logic [31:0] d);
        bit ok;
        @(negedge clk);
        hostReq   = 1'b1;
        hostWe    = 1'b1;
        hostAddr  = a[`RV_ADDR_W-1:0];
        hostWdata = d;
        waitGrant(ok);
        @(negedge clk);
        hostReq = 1'b0;
        hostWe  = 1'b0;
        if (!ok) begin
            timeouts++;
            $display("Timeout: host write to word %0d was never granted", a);
        end
    endtask

    task automatic hostRead(input int a, output logic [31:0] d);
        bit ok, got;
        int n;
        d = 'x;
        got = 1'b0;
        @(negedge clk);
        hostReq  = 1'b1;
        hostWe   = 1'b0;
        hostAddr = a[`RV_ADDR_W-1:0];
        waitGrant(ok);
        for (n = 0; n < gntLimit && ok && !got; n++) begin
            @(negedge clk);
            hostReq = 1'b0;
            got = hostRvalid;
            if (got)
                d = hostRdata;
        end
        if (!got) begin
            hostReq = 1'b0;
            timeouts++;
            $display("Timeout: host read of word %0d got no %s", a, ok ? "data" : "grant");
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic waitHalt();
        int n;
        for (n = 0; n < haltLimit && !halted; n++)
            @(negedge clk);
        if (!halted) begin
            timeouts++;
            $display("Timeout: core did not halt within %0d cycles", haltLimit);
        end
    endtask

    // Reads program words at random gaps while the core competes for the bus
    task automatic pollHost();
        int          gap, n, idx;
        logic [31:0] d;
        while (!halted && timeouts == 0) begin
            gap = 1 + ($unsigned($random(seed)) % 8);
            for (n = 0; n < gap && !halted; n++)
                @(negedge clk);
            if (!halted) begin
                idx = $unsigned($random(seed)) % prog.size();
                hostRead(idx, d);
                checkWord($sformatf("host read of word %0d while running", idx), prog[idx], d);
            end
        end
    endtask

    initial begin
        int          i;
        logic [31:0] d;
        rstN        = 1'b0;
        run         = 1'b0;
        hostReq     = 1'b0;
        hostWe      = 1'b0;
        hostAddr    = '0;
        hostWdata   = '0;
        seed        = 32'h9f14_94d4;
        resultSlots = 0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        buildProgram();
        for (i = 0; i < prog.size(); i++)
            hostWrite(i, prog[i]);
        hostWrite(dataBase, dataWord);
        for (i = 1; i <= 4; i++)
            hostWrite(dataBase + i, fillWord(dataBase + i));

        @(negedge clk);
        run = 1'b1;
        fork
            waitHalt();
            pollHost();
        join

        for (i = 0; i < expName.size() && timeouts == 0; i++) begin
            hostRead(expAddr[i], d);
            checkWord(expName[i], expVal[i], d);
        end

        $display("Checks %0d, errors %0d, timeouts %0d, property failures %0d",
                 checks, errors, timeouts, uut.props.propFails);
        if (errors == 0 && timeouts == 0 && uut.props.propFails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
rv_pkg.sv
mem_bus_if.sv
main_decode.sv
rv_core.sv
load_store_unit.sv
bus_arbiter.sv
unified_mem.sv
rv_top.sv
rv_props.sv
rv_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module rv_tb -f src.f -o rv_sim \
    && ./obj_dir/rv_sim +verilator+error+limit+100 2>&1 | tee sim.log
grep -q "=== PASS ===" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
